// ==== qpi_memctrl_top.f ====
hw/qpi_pkg.sv
hw/qpi_ctrl_fsm.sv
hw/qpi_shift_out.sv
hw/qpi_shift_in.sv
hw/qpi_memctrl_top.sv
sim/qpi_mem_model.sv
sim/tb_qpi_memctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_qpi_memctrl
FILELIST  := qpi_memctrl_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_qpi_memctrl.sv ====
/* Testbench of the QPI memory controller. Runs write bursts, read-backs and a
   fresh read on both chip selects against the memory model. */

module tb_qpi_memctrl;

	localparam logic [15:0] CMD_READ  = 16'hEB6B;
	localparam logic [15:0] CMD_WRITE = 16'h3802;
	localparam int          DUMMY_CLK = 6;
	localparam int          PAUSE_CLK = 3;
	localparam int          PHY_DELAY = 6;
	localparam qpi_pkg::word_t FILL   = 32'h5A3C_96E1;

	logic clk = 1'b0;
	logic rst = 1'b1;

	logic           mi_addr_cs_i;
	qpi_pkg::addr_t mi_addr_i;
	qpi_pkg::len_t  mi_len_i;
	logic           mi_rw_i;
	logic           mi_valid_i;
	qpi_pkg::word_t mi_wdata_i;
	logic           mi_ready_o;
	logic           mi_wack_o;
	logic           mi_wlast_o;
	qpi_pkg::word_t mi_rdata_o;
	logic           mi_rstb_o;
	logic           mi_rlast_o;
	qpi_pkg::nib_t  phy_io_i;
	qpi_pkg::nib_t  phy_io_o;
	logic [3:0]     phy_io_oe_o;
	logic           phy_clk_o;
	logic [1:0]     phy_cs_o;

	logic [7:0]     m_cmd;
	qpi_pkg::addr_t m_addr;
	logic           m_cmd_stb;
	qpi_pkg::word_t m_wword;
	logic           m_wword_stb;

	// Checker state
	string          test_name = "reset";
	int             errors = 0;
	int             cycles = 0;
	int             limit = 1000;
	int             gap_cnt = 0;
	logic           rst_q = 1'b1;
	logic           ready_q = 1'b1;
	logic           cur_cs = 1'b0;
	logic [7:0]     exp_cmd = '0;
	qpi_pkg::addr_t exp_addr = '0;
	qpi_pkg::len_t  exp_len = '0;
	logic [6:0]     wack_cnt = '0;
	logic [6:0]     wchk_idx = '0;
	logic [6:0]     rstb_cnt = '0;
	qpi_pkg::word_t wr_words [0:127];
	qpi_pkg::word_t rd_exp [0:127];
	qpi_pkg::word_t burst [0:127];
	qpi_pkg::word_t exp_wword;
	qpi_pkg::word_t exp_rword;
	qpi_pkg::len_t  lens [0:2];
	qpi_pkg::addr_t addrs [0:2];

	always #20 clk = ~clk;

	qpi_memctrl_top #(
		.CMD_READ  (CMD_READ),
		.CMD_WRITE (CMD_WRITE),
		.DUMMY_CLK (DUMMY_CLK),
		.PAUSE_CLK (PAUSE_CLK),
		.PHY_DELAY (PHY_DELAY),
		.N_CS      (2)
	) dut (
		.clk          (clk),
		.rst          (rst),
		.mi_addr_cs_i (mi_addr_cs_i),
		.mi_addr_i    (mi_addr_i),
		.mi_len_i     (mi_len_i),
		.mi_rw_i      (mi_rw_i),
		.mi_valid_i   (mi_valid_i),
		.mi_ready_o   (mi_ready_o),
		.mi_wdata_i   (mi_wdata_i),
		.mi_wack_o    (mi_wack_o),
		.mi_wlast_o   (mi_wlast_o),
		.mi_rdata_o   (mi_rdata_o),
		.mi_rstb_o    (mi_rstb_o),
		.mi_rlast_o   (mi_rlast_o),
		.phy_io_i     (phy_io_i),
		.phy_io_o     (phy_io_o),
		.phy_io_oe_o  (phy_io_oe_o),
		.phy_clk_o    (phy_clk_o),
		.phy_cs_o     (phy_cs_o)
	);

	qpi_mem_model #(
		.CMD_READ  (CMD_READ),
		.CMD_WRITE (CMD_WRITE),
		.DUMMY_CLK (DUMMY_CLK),
		.PHY_DELAY (PHY_DELAY)
	) u_mem (
		.clk         (clk),
		.phy_cs_i    (phy_cs_o),
		.phy_clk_i   (phy_clk_o),
		.phy_io_i    (phy_io_o),
		.phy_io_o    (phy_io_i),
		.cmd_o       (m_cmd),
		.addr_o      (m_addr),
		.cmd_stb_o   (m_cmd_stb),
		.wword_o     (m_wword),
		.wword_stb_o (m_wword_stb)
	);

	assign exp_wword = wr_words[wchk_idx];
	assign exp_rword = rd_exp[rstb_cnt];

	// ----------------------------------------
	// Bookkeeping
	// ----------------------------------------

	always @(posedge clk)
	begin
		rst_q   <= rst;
		ready_q <= mi_ready_o;
		if (mi_valid_i && mi_ready_o)
		begin
			cur_cs   <= mi_addr_cs_i;
			wack_cnt <= '0;
			wchk_idx <= '0;
			rstb_cnt <= '0;
		end
		else
		begin
			if (mi_wack_o)
			begin
				wr_words[wack_cnt] <= mi_wdata_i;
				wack_cnt <= wack_cnt + 7'd1;
			end
			if (m_wword_stb)
				wchk_idx <= wchk_idx + 7'd1;
			if (mi_rstb_o)
				rstb_cnt <= rstb_cnt + 7'd1;
		end
		// Cycles with every memory deselected while not ready
		if (mi_ready_o)
			gap_cnt <= 0;
		else if (&phy_cs_o)
			gap_cnt <= gap_cnt + 1;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > limit)
		begin
			$display("Timeout: run did not finish within %0d cycles", limit);
			$display("Test failures found");
			$finish;
		end
	end

	// ----------------------------------------
	// Checks
	// ----------------------------------------

	a_reset_state: assert property (@(posedge clk) (rst_q && !rst) |->
		(phy_cs_o == 2'b11 && !phy_clk_o && phy_io_oe_o == 4'b0000 && mi_ready_o))
		else
		begin
			errors++;
			$display("After reset the PHY pins or mi_ready_o are not in the idle state");
		end

	a_cmd_byte: assert property (@(posedge clk) disable iff (rst)
		m_cmd_stb |-> m_cmd == exp_cmd)
		else
		begin
			errors++;
			$display("MISMATCH %s cmd expected %h actual %h", test_name, exp_cmd, $sampled(m_cmd));
		end

	a_cmd_addr: assert property (@(posedge clk) disable iff (rst)
		m_cmd_stb |-> m_addr == exp_addr)
		else
		begin
			errors++;
			$display("MISMATCH %s addr expected %h actual %h", test_name, exp_addr,
				$sampled(m_addr));
		end

	a_wr_word: assert property (@(posedge clk) disable iff (rst)
		m_wword_stb |-> m_wword == exp_wword)
		else
		begin
			errors++;
			$display("MISMATCH %s write word expected %h actual %h", test_name,
				$sampled(exp_wword), $sampled(m_wword));
		end

	a_wlast: assert property (@(posedge clk) disable iff (rst)
		mi_wack_o |-> mi_wlast_o == (wack_cnt == exp_len))
		else
		begin
			errors++;
			$display("MISMATCH %s wlast expected %b actual %b", test_name,
				$sampled(wack_cnt == exp_len), $sampled(mi_wlast_o));
		end

	a_rd_word: assert property (@(posedge clk) disable iff (rst)
		mi_rstb_o |-> mi_rdata_o == exp_rword)
		else
		begin
			errors++;
			$display("MISMATCH %s read word expected %h actual %h", test_name,
				$sampled(exp_rword), $sampled(mi_rdata_o));
		end

	a_rlast: assert property (@(posedge clk) disable iff (rst)
		mi_rstb_o |-> mi_rlast_o == (rstb_cnt == exp_len))
		else
		begin
			errors++;
			$display("MISMATCH %s rlast expected %b actual %b", test_name,
				$sampled(rstb_cnt == exp_len), $sampled(mi_rlast_o));
		end

	a_cs_match: assert property (@(posedge clk) disable iff (rst)
		!(&phy_cs_o) |-> phy_cs_o == (cur_cs ? 2'b01 : 2'b10))
		else
		begin
			errors++;
			$display("MISMATCH %s cs expected %b actual %b", test_name,
				$sampled(cur_cs ? 2'b01 : 2'b10), $sampled(phy_cs_o));
		end

	a_clk_cs: assert property (@(posedge clk) disable iff (rst)
		phy_clk_o |-> !(&phy_cs_o))
		else
		begin
			errors++;
			$display("PHY clock pulsed with no chip select low in %s", test_name);
		end

	a_pause: assert property (@(posedge clk) disable iff (rst)
		(mi_ready_o && !ready_q) |-> gap_cnt == PAUSE_CLK)
		else
		begin
			errors++;
			$display("MISMATCH %s pause expected %0d actual %0d", test_name, PAUSE_CLK,
				$sampled(gap_cnt));
		end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------

	task automatic wait_ready();
		@(posedge clk);
		while (!mi_ready_o)
			@(posedge clk);
		#5;
	endtask

	task automatic start_req(input logic cs, input qpi_pkg::addr_t addr,
		input qpi_pkg::len_t len, input logic rw);
		exp_addr = addr;
		exp_len  = len;
		// Low byte of each command belongs to memory 0
		case ({rw, cs})
			2'b00:   exp_cmd = CMD_WRITE[7:0];
			2'b01:   exp_cmd = CMD_WRITE[15:8];
			2'b10:   exp_cmd = CMD_READ[7:0];
			default: exp_cmd = CMD_READ[15:8];
		endcase
		mi_addr_cs_i = cs;
		mi_addr_i    = addr;
		mi_len_i     = len;
		mi_rw_i      = rw;
		mi_valid_i   = 1'b1;
		@(posedge clk);
		while (!mi_ready_o)
			@(posedge clk);
		#5;
		mi_valid_i = 1'b0;
	endtask

	task automatic write_burst(input logic cs, input qpi_pkg::addr_t addr,
		input qpi_pkg::len_t len);
		int n;
		n = 0;
		for (int i = 0; i <= int'(len); i++)
			burst[7'(i)] = $urandom;
		mi_wdata_i = burst[0];
		start_req(cs, addr, len, 1'b0);
		while (n < int'(len) + 1)
		begin
			@(posedge clk);
			if (mi_wack_o)
			begin
				n++;
				#5;
				if (n <= int'(len))
					mi_wdata_i = burst[7'(n)];
			end
		end
		wait_ready();
		assert (wack_cnt == 7'(len) + 7'd1)
			else
			begin
				errors++;
				$display("MISMATCH %s wack count expected %0d actual %0d", test_name,
					int'(len) + 1, wack_cnt);
			end
	endtask

	task automatic read_burst(input logic cs, input qpi_pkg::addr_t addr,
		input qpi_pkg::len_t len, input logic fresh);
		qpi_pkg::addr_t a;
		for (int i = 0; i <= int'(len); i++)
		begin
			a = addr + qpi_pkg::addr_t'(4 * i);
			rd_exp[7'(i)] = fresh ? ({8'h00, a} ^ FILL) : burst[7'(i)];
		end
		start_req(cs, addr, len, 1'b1);
		while (rstb_cnt < 7'(len) + 7'd1)
			@(posedge clk);
		wait_ready();
		repeat (PHY_DELAY + 2) @(posedge clk);
		#5;
		assert (rstb_cnt == 7'(len) + 7'd1)
			else
			begin
				errors++;
				$display("MISMATCH %s rstb count expected %0d actual %0d", test_name,
					int'(len) + 1, rstb_cnt);
			end
	endtask

	initial
	begin
		void'($urandom(41635));
		mi_addr_cs_i = 1'b0;
		mi_addr_i    = '0;
		mi_len_i     = '0;
		mi_rw_i      = 1'b0;
		mi_valid_i   = 1'b0;
		mi_wdata_i   = '0;

		// Short bursts in three separate regions
		limit = 200;
		for (int i = 0; i < 3; i++)
		begin
			lens[i]  = qpi_pkg::len_t'($urandom % 16);
			addrs[i] = qpi_pkg::addr_t'((i << 22) | ($urandom & 32'h003F_FFFC));
			limit += 2 * (12 + DUMMY_CLK + 8 * (int'(lens[i]) + 1) + PAUSE_CLK + PHY_DELAY + 10);
		end

		repeat (16) @(posedge clk);
		#5;
		rst = 1'b0;
		@(posedge clk);
		#5;

		test_name = "write_cs0";
		write_burst(1'b0, addrs[0], lens[0]);
		test_name = "readback_cs0";
		read_burst(1'b0, addrs[0], lens[0], 1'b0);
		test_name = "write_cs1";
		write_burst(1'b1, addrs[1], lens[1]);
		test_name = "readback_cs1";
		read_burst(1'b1, addrs[1], lens[1], 1'b0);
		test_name = "fresh_read_cs1";
		read_burst(1'b1, addrs[2], lens[2], 1'b1);

		$display("Run complete after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== sim/qpi_mem_model.sv ====
/* Behavioural QPI memory for the testbench. Decodes command and address, stores
   write words per chip select and returns read nibbles after the PHY delay. */

module qpi_mem_model #(
	parameter logic [15:0] CMD_READ  = 16'hEBEB,
	parameter logic [15:0] CMD_WRITE = 16'h0202,
	parameter int          DUMMY_CLK = 6,
	parameter int          PHY_DELAY = 6
)(
	input  logic           clk,
	input  logic [1:0]     phy_cs_i,
	input  logic           phy_clk_i,
	input  qpi_pkg::nib_t  phy_io_i,
	output qpi_pkg::nib_t  phy_io_o,

	// Decoded header and write words, for the checker
	output logic [7:0]     cmd_o,
	output qpi_pkg::addr_t addr_o,
	output logic           cmd_stb_o,
	output qpi_pkg::word_t wword_o,
	output logic           wword_stb_o
);

	// Content of locations never written
	localparam qpi_pkg::word_t FILL = 32'h5A3C_96E1;

	qpi_pkg::word_t mem [int];
	qpi_pkg::nib_t  pipe [0:PHY_DELAY-1];

	int             ncnt = 0;
	logic [31:0]    hdr = '0;
	qpi_pkg::word_t wacc = '0;
	qpi_pkg::addr_t base = '0;
	logic           rd_cmd = 1'b0;
	logic           wr_cmd = 1'b0;

	initial
	begin
		for (int i = 0; i < PHY_DELAY; i++)
			pipe[i] = '0;
		cmd_stb_o = 1'b0;
		wword_stb_o = 1'b0;
	end

	function automatic qpi_pkg::word_t fetch(logic cs, qpi_pkg::addr_t a);
		int key;
		key = int'({cs, a});
		if (mem.exists(key))
			return mem[key];
		return {8'h00, a} ^ FILL;
	endfunction

	always @(posedge clk)
	begin : decode
		logic           cs_sel;
		qpi_pkg::nib_t  nib_out;
		logic [31:0]    hdr_n;
		qpi_pkg::word_t word_n;
		qpi_pkg::addr_t waddr;
		int             k;

		cmd_stb_o   <= 1'b0;
		wword_stb_o <= 1'b0;
		nib_out = '0;
		// Bit 0 is high only when memory 1 is the one selected
		cs_sel = phy_cs_i[0];

		if (&phy_cs_i)
			ncnt <= 0;
		else if (phy_clk_i)
		begin
			if (ncnt < qpi_pkg::NIB_PER_WORD)
			begin
				hdr_n = {hdr[27:0], phy_io_i};
				hdr <= hdr_n;
				if (ncnt == qpi_pkg::NIB_PER_WORD - 1)
				begin
					cmd_o     <= hdr_n[31:24];
					addr_o    <= hdr_n[23:0];
					cmd_stb_o <= 1'b1;
					base      <= hdr_n[23:0];
					rd_cmd    <= (hdr_n[31:24] == CMD_READ[8*cs_sel +: 8]);
					wr_cmd    <= (hdr_n[31:24] == CMD_WRITE[8*cs_sel +: 8]);
				end
			end
			else if (wr_cmd)
			begin
				k = ncnt - qpi_pkg::NIB_PER_WORD;
				word_n = {wacc[27:0], phy_io_i};
				wacc <= word_n;
				if (k % 8 == 7)
				begin
					waddr = base + qpi_pkg::addr_t'(4 * (k / 8));
					mem[int'({cs_sel, waddr})] = word_n;
					wword_o     <= word_n;
					wword_stb_o <= 1'b1;
				end
			end
			else if (rd_cmd && ncnt >= qpi_pkg::NIB_PER_WORD + DUMMY_CLK)
			begin
				k = ncnt - qpi_pkg::NIB_PER_WORD - DUMMY_CLK;
				word_n = fetch(cs_sel, base + qpi_pkg::addr_t'(4 * (k / 8)));
				nib_out = word_n[31 - 4 * (k % 8) -: 4];
			end
			ncnt <= ncnt + 1;
		end

		// Read nibbles reach the pins PHY_DELAY cycles after their clock
		pipe[0] <= nib_out;
		for (int i = 1; i < PHY_DELAY; i++)
			pipe[i] <= pipe[i-1];
	end

	assign phy_io_o = pipe[PHY_DELAY-1];

endmodule

// ==== hw/qpi_memctrl_top.sv ====
/* QPI memory controller for quad-SPI PSRAM or flash on a single lane.
   Burst requests come in on the mi_ ports, the memory hangs off the phy_ ports. */

module qpi_memctrl_top #(
	parameter logic [15:0] CMD_READ  = 16'hEBEB,
	parameter logic [15:0] CMD_WRITE = 16'h0202,
	parameter int          DUMMY_CLK = 6,
	parameter int          PAUSE_CLK = 3,
	parameter int          PHY_DELAY = 6,
	parameter int          N_CS      = 2
)(
	input  logic                            clk,
	input  logic                            rst,

	// Memory interface
	input  logic                            mi_addr_cs_i,
	input  qpi_pkg::addr_t                  mi_addr_i,
	input  qpi_pkg::len_t                   mi_len_i,
	input  logic                            mi_rw_i,
	input  logic                            mi_valid_i,
	output logic                            mi_ready_o,
	input  qpi_pkg::word_t                  mi_wdata_i,
	output logic                            mi_wack_o,
	output logic                            mi_wlast_o,
	output qpi_pkg::word_t                  mi_rdata_o,
	output logic                            mi_rstb_o,
	output logic                            mi_rlast_o,

	// PHY
	input  qpi_pkg::nib_t                   phy_io_i,
	output qpi_pkg::nib_t                   phy_io_o,
	output logic [qpi_pkg::IO_LINES-1:0]    phy_io_oe_o,
	output logic                            phy_clk_o,
	output logic [N_CS-1:0]                 phy_cs_o
);

	// Sequencer to shifter
	logic            ld_now;
	logic            ld_valid;
	logic            ld_drive;
	qpi_pkg::sodst_t ld_dst;
	qpi_pkg::shcnt_t ld_cnt;
	qpi_pkg::word_t  ld_word;

	// Shift-out to shift-in
	logic            so_valid;
	logic            so_last;
	qpi_pkg::sodst_t so_dst;

	qpi_ctrl_fsm #(
		.CMD_READ  (CMD_READ),
		.CMD_WRITE (CMD_WRITE),
		.DUMMY_CLK (DUMMY_CLK),
		.PAUSE_CLK (PAUSE_CLK),
		.N_CS      (N_CS)
	) u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.mi_addr_cs_i (mi_addr_cs_i),
		.mi_addr_i    (mi_addr_i),
		.mi_len_i     (mi_len_i),
		.mi_rw_i      (mi_rw_i),
		.mi_valid_i   (mi_valid_i),
		.mi_wdata_i   (mi_wdata_i),
		.mi_ready_o   (mi_ready_o),
		.mi_wack_o    (mi_wack_o),
		.mi_wlast_o   (mi_wlast_o),
		.ld_now_i     (ld_now),
		.so_valid_i   (so_valid),
		.ld_valid_o   (ld_valid),
		.ld_drive_o   (ld_drive),
		.ld_dst_o     (ld_dst),
		.ld_cnt_o     (ld_cnt),
		.ld_word_o    (ld_word),
		.phy_cs_o     (phy_cs_o)
	);

	qpi_shift_out u_shift_out (
		.clk         (clk),
		.rst         (rst),
		.ld_valid_i  (ld_valid),
		.ld_drive_i  (ld_drive),
		.ld_dst_i    (ld_dst),
		.ld_cnt_i    (ld_cnt),
		.ld_word_i   (ld_word),
		.ld_now_o    (ld_now),
		.so_valid_o  (so_valid),
		.so_last_o   (so_last),
		.so_dst_o    (so_dst),
		.phy_io_o    (phy_io_o),
		.phy_io_oe_o (phy_io_oe_o),
		.phy_clk_o   (phy_clk_o)
	);

	qpi_shift_in #(
		.PHY_DELAY (PHY_DELAY)
	) u_shift_in (
		.clk        (clk),
		.so_valid_i (so_valid),
		.so_last_i  (so_last),
		.so_dst_i   (so_dst),
		.phy_io_i   (phy_io_i),
		.mi_rdata_o (mi_rdata_o),
		.mi_rstb_o  (mi_rstb_o),
		.mi_rlast_o (mi_rlast_o)
	);

endmodule

// ==== hw/qpi_shift_in.sv ====
/* Capture side of the QPI controller. Follows the receive phases through
   the PHY delay and assembles inbound nibbles into read words. */

module qpi_shift_in #(
	parameter int PHY_DELAY = 6
)(
	input  logic            clk,

	// Phase info from the shift-out unit
	input  logic            so_valid_i,
	input  logic            so_last_i,
	input  qpi_pkg::sodst_t so_dst_i,

	input  qpi_pkg::nib_t   phy_io_i,

	// Read words to the requester
	output qpi_pkg::word_t  mi_rdata_o,
	output logic            mi_rstb_o,
	output logic            mi_rlast_o
);

	localparam int WW = $bits(qpi_pkg::word_t);
	localparam int NW = $bits(qpi_pkg::nib_t);

	// Stage 0 is the capture marker, the rest match the PHY pipeline
	qpi_pkg::sodst_t dly_q [0:PHY_DELAY];

	qpi_pkg::word_t  si_data;

	// ----------------------------------------
	// Capture marker and delay line
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (so_valid_i && so_last_i)
			dly_q[0] <= so_dst_i;
		else
			dly_q[0] <= qpi_pkg::NONE;

		for (int i = 1; i <= PHY_DELAY; i++)
			dly_q[i] <= dly_q[i-1];
	end

	// ----------------------------------------
	// Nibble shift-in
	// ----------------------------------------

	// Free running, first nibble ends up on top
	always_ff @(posedge clk)
	begin
		si_data <= {si_data[WW-NW-1:0], phy_io_i};
	end

	assign mi_rdata_o = si_data;
	assign mi_rstb_o  = dly_q[PHY_DELAY][1];
	assign mi_rlast_o = (dly_q[PHY_DELAY] == qpi_pkg::MI_LAST);

	// Words are at least a full nibble count apart
	a_rstb_gap: assert property (@(posedge clk)
		mi_rstb_o |=> !mi_rstb_o)
		else $error("read strobe in consecutive cycles");

endmodule

// ==== hw/qpi_shift_out.sv ====
/* Output shifter of the QPI controller. Takes a word and a cycle count
   from the sequencer and clocks nibbles onto the PHY pins. */

module qpi_shift_out (
	input  logic                            clk,
	input  logic                            rst,

	// Load request from the sequencer
	input  logic                            ld_valid_i,
	input  logic                            ld_drive_i,
	input  qpi_pkg::sodst_t                 ld_dst_i,
	input  qpi_pkg::shcnt_t                 ld_cnt_i,
	input  qpi_pkg::word_t                  ld_word_i,
	output logic                            ld_now_o,

	// Phase info for the capture side
	output logic                            so_valid_o,
	output logic                            so_last_o,
	output qpi_pkg::sodst_t                 so_dst_o,

	// PHY
	output qpi_pkg::nib_t                   phy_io_o,
	output logic [qpi_pkg::IO_LINES-1:0]    phy_io_oe_o,
	output logic                            phy_clk_o
);

	localparam int WW = $bits(qpi_pkg::word_t);
	localparam int NW = $bits(qpi_pkg::nib_t);
	localparam int CW = $bits(qpi_pkg::shcnt_t);

	logic            so_drive;
	qpi_pkg::shcnt_t so_cnt;
	qpi_pkg::word_t  so_data;

	// ----------------------------------------
	// Control
	// ----------------------------------------

	// Reload when empty or finishing a phase
	assign ld_now_o  = !so_valid_o || so_last_o;
	assign so_last_o = so_cnt[CW-1];

	always_ff @(posedge clk)
	begin
		if (rst)
			so_valid_o <= 1'b0;
		else
			so_valid_o <= (so_valid_o && !so_last_o) || (ld_now_o && ld_valid_i);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			so_drive <= 1'b0;
			so_dst_o <= qpi_pkg::NONE;
		end
		else if (ld_now_o)
		begin
			so_drive <= ld_drive_i;
			so_dst_o <= ld_dst_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ld_now_o)
			so_cnt <= ld_cnt_i;
		else
			so_cnt <= so_cnt - CW'(1);
	end

	// ----------------------------------------
	// Data shifter
	// ----------------------------------------

	// Top nibble goes out, rest moves up
	always_ff @(posedge clk)
	begin
		if (ld_now_o)
			so_data <= ld_word_i;
		else
			so_data <= {so_data[WW-NW-1:0], NW'(0)};
	end

	assign phy_io_o    = so_data[WW-1 -: NW];
	assign phy_clk_o   = so_valid_o;
	assign phy_io_oe_o = (so_valid_o && so_drive) ? qpi_pkg::OE_DRIVE : qpi_pkg::OE_FLOAT;

	// IO lines only driven in an active phase that captures no read word
	a_oe_phase: assert property (@(posedge clk) disable iff (rst)
		(phy_io_oe_o != qpi_pkg::OE_FLOAT) |-> so_valid_o && (so_dst_o == qpi_pkg::NONE))
		else $error("PHY driven outside a drive phase");

endmodule

// ==== hw/qpi_ctrl_fsm.sv ====
/* Transaction sequencer of the QPI controller. Accepts one request at a time,
   drives chip select and tells the shift-out unit what to load for each phase. */

module qpi_ctrl_fsm #(
	parameter logic [15:0] CMD_READ  = 16'hEBEB,
	parameter logic [15:0] CMD_WRITE = 16'h0202,
	parameter int          DUMMY_CLK = 6,
	parameter int          PAUSE_CLK = 3,
	parameter int          N_CS      = 2
)(
	input  logic                clk,
	input  logic                rst,

	// Request side
	input  logic                mi_addr_cs_i,
	input  qpi_pkg::addr_t      mi_addr_i,
	input  qpi_pkg::len_t       mi_len_i,
	input  logic                mi_rw_i,
	input  logic                mi_valid_i,
	input  qpi_pkg::word_t      mi_wdata_i,
	output logic                mi_ready_o,
	output logic                mi_wack_o,
	output logic                mi_wlast_o,

	// Shift-out load control
	input  logic                ld_now_i,
	input  logic                so_valid_i,
	output logic                ld_valid_o,
	output logic                ld_drive_o,
	output qpi_pkg::sodst_t     ld_dst_o,
	output qpi_pkg::shcnt_t     ld_cnt_o,
	output qpi_pkg::word_t      ld_word_o,

	output logic [N_CS-1:0]     phy_cs_o
);

	localparam int XW = $bits(qpi_pkg::len_t) + 1;
	localparam int PW = $clog2(PAUSE_CLK) + 1;

	// Shifter counts run down to -1
	localparam qpi_pkg::shcnt_t WORD_CNT  = qpi_pkg::shcnt_t'(qpi_pkg::NIB_PER_WORD - 2);
	localparam qpi_pkg::shcnt_t DUMMY_CNT = qpi_pkg::shcnt_t'(DUMMY_CLK - 2);

	qpi_pkg::phase_t state;
	qpi_pkg::phase_t state_nxt;

	logic [XW-1:0] xfer_cnt;
	logic          xfer_last;
	logic          data_load;

	logic [PW-1:0] pause_cnt;
	logic          pause_last;

	logic [7:0]    cmd_byte;

	// ----------------------------------------
	// State machine
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= qpi_pkg::IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			qpi_pkg::IDLE:
				if (mi_valid_i)
					state_nxt = mi_rw_i ? qpi_pkg::RD_DUMMY : qpi_pkg::WR_DATA;
			qpi_pkg::WR_DATA:
				if (xfer_last && ld_now_i)
					state_nxt = qpi_pkg::FLUSH;
			// Dummy phase gets loaded as the command ends
			qpi_pkg::RD_DUMMY:
				if (ld_now_i)
					state_nxt = qpi_pkg::RD_DATA;
			qpi_pkg::RD_DATA:
				if (xfer_last && ld_now_i)
					state_nxt = qpi_pkg::FLUSH;
			qpi_pkg::FLUSH:
				if (!so_valid_i)
					state_nxt = qpi_pkg::PAUSE;
			qpi_pkg::PAUSE:
				if (pause_last)
					state_nxt = qpi_pkg::IDLE;
			default:
				state_nxt = qpi_pkg::IDLE;
		endcase
	end

	// ----------------------------------------
	// Word and pause counters
	// ----------------------------------------

	assign data_load = ld_now_i &&
		((state == qpi_pkg::WR_DATA) || (state == qpi_pkg::RD_DATA));

	always_ff @(posedge clk)
	begin
		if (rst)
			xfer_cnt <= '0;
		else if (state == qpi_pkg::IDLE)
			xfer_cnt <= {1'b0, mi_len_i} - XW'(1);
		else if (data_load)
			xfer_cnt <= xfer_cnt - XW'(1);
	end

	// Underflow marks the final word
	assign xfer_last = xfer_cnt[XW-1];

	always_ff @(posedge clk)
	begin
		if (rst)
			pause_cnt <= PW'(PAUSE_CLK - 2);
		else if (state == qpi_pkg::PAUSE)
			pause_cnt <= pause_cnt - PW'(1);
		else
			pause_cnt <= PW'(PAUSE_CLK - 2);
	end

	assign pause_last = pause_cnt[PW-1];

	// ----------------------------------------
	// Shifter load requests
	// ----------------------------------------

	// One command byte per chip select
	assign cmd_byte = mi_rw_i ? CMD_READ[8*mi_addr_cs_i +: 8] : CMD_WRITE[8*mi_addr_cs_i +: 8];

	always_comb
	begin
		ld_valid_o = 1'b0;
		ld_drive_o = 1'b0;
		ld_dst_o   = qpi_pkg::NONE;
		ld_cnt_o   = WORD_CNT;
		ld_word_o  = qpi_pkg::word_t'({cmd_byte, mi_addr_i});
		case (state)
			qpi_pkg::IDLE:
			begin
				ld_valid_o = mi_valid_i;
				ld_drive_o = 1'b1;
			end
			qpi_pkg::WR_DATA:
			begin
				ld_valid_o = 1'b1;
				ld_drive_o = 1'b1;
				ld_word_o  = mi_wdata_i;
			end
			qpi_pkg::RD_DUMMY:
			begin
				ld_valid_o = 1'b1;
				ld_cnt_o   = DUMMY_CNT;
			end
			qpi_pkg::RD_DATA:
			begin
				ld_valid_o = 1'b1;
				ld_dst_o   = xfer_last ? qpi_pkg::MI_LAST : qpi_pkg::MI_DATA;
			end
			default:
			begin
				ld_valid_o = 1'b0;
			end
		endcase
	end

	assign mi_ready_o = (state == qpi_pkg::IDLE);
	assign mi_wack_o  = (state == qpi_pkg::WR_DATA) && ld_now_i;
	assign mi_wlast_o = (state == qpi_pkg::WR_DATA) && xfer_last;

	// ----------------------------------------
	// Chip select
	// ----------------------------------------

	always_ff @(posedge clk)
	begin
		if (rst)
			phy_cs_o <= '1;
		else
		begin
			case (state)
				qpi_pkg::IDLE:
				begin
					phy_cs_o <= '1;
					if (mi_valid_i)
						phy_cs_o[mi_addr_cs_i] <= 1'b0;
				end
				qpi_pkg::FLUSH:
					if (!so_valid_i)
						phy_cs_o <= '1;
				qpi_pkg::PAUSE:
					phy_cs_o <= '1;
				default:
					phy_cs_o <= phy_cs_o;
			endcase
		end
	end

	// Never two memories selected, and one always selected while shifting
	a_one_cs: assert property (@(posedge clk) disable iff (rst)
		($countones(~phy_cs_o) <= 1) && (!so_valid_i || !(&phy_cs_o)))
		else $error("chip select count does not match shifter activity");

endmodule

// ==== hw/qpi_pkg.sv ====
/* Shared types and constants of the QPI memory controller.
   Every RTL block refers to these by scoped name. */

package qpi_pkg;

	// ----------------------------------------
	// PHY constants
	// ----------------------------------------

	// Four IO lines in QPI mode
	localparam int IO_LINES = 4;

	localparam logic [IO_LINES-1:0] OE_DRIVE = 4'b1111;
	localparam logic [IO_LINES-1:0] OE_FLOAT = 4'b0000;

	// ----------------------------------------
	// Data widths
	// ----------------------------------------

	typedef logic [23:0] addr_t;

	// Big endian, b3 goes out first, high nibble first
	typedef logic [31:0] word_t;

	// Bit i is IO line i
	typedef logic [IO_LINES-1:0] nib_t;

	// Burst length, value + 1 words
	typedef logic [6:0] len_t;

	// Shifter cycle count, top bit flags the last cycle
	typedef logic [5:0] shcnt_t;

	localparam int NIB_PER_WORD = $bits(word_t) / IO_LINES;

	// ----------------------------------------
	// Encodings
	// ----------------------------------------

	typedef enum logic [2:0] {
		IDLE,
		WR_DATA,
		RD_DUMMY,
		RD_DATA,
		FLUSH,
		PAUSE
	} phase_t;

	// Bit 1 makes a read word, bit 0 flags the last one
	typedef enum logic [1:0] {
		NONE    = 2'b00,
		MI_DATA = 2'b10,
		MI_LAST = 2'b11
	} sodst_t;

endpackage
